// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = bk_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# The run exits with a failing status on any $fatal or assertion error
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
source/bk_pkg.sv
source/bk_stage_if.sv
source/bk_gprs.sv
source/bk_dispatch.sv
source/bk_execute.sv
source/bk_writeback.sv
source/bk_top.sv
test/bk_checker.sv
test/bk_tb.sv

// ==== source/bk_dispatch.sv ====
/*
 * Dispatch stage. Keeps the decode-aligned PC, reads the GPRs, resolves
 * read-after-write hazards by forwarding and gathers operands A and B.
 * Forward priority is youngest first: s3, then the execute register,
 * then s4, then the register file. No stalls are needed without loads.
 * The PC steps by 4 on every accepted micro-op, there is no branching.
 */
module bk_dispatch (
    input  logic              g_clk,            // Clock
    input  logic              g_resetn,         // Sync reset, active low
    input  logic              in_valid,         // Micro-op offered
    output logic              in_busy,          // Cannot take it now
    input  bk_pkg::reg_addr_t in_rd,            // Destination register
    input  bk_pkg::reg_addr_t in_rs1,           // Source register 1
    input  bk_pkg::reg_addr_t in_rs2,           // Source register 2
    input  bk_pkg::word_t     in_imm,           // Decoded immediate
    input  bk_pkg::alu_uop_e  in_uop,           // ALU micro-op
    input  bk_pkg::opr_src_t  in_opr_src,       // Operand source selects
    output bk_pkg::reg_addr_t rs1_addr,         // GPR read address 1
    output bk_pkg::reg_addr_t rs2_addr,         // GPR read address 2
    input  bk_pkg::word_t     rs1_data,         // GPR read data 1
    input  bk_pkg::word_t     rs2_data,         // GPR read data 2
    input  logic              fwd_s3_valid,     // ALU result of s3 item
    input  bk_pkg::reg_addr_t fwd_s3_rd,
    input  bk_pkg::word_t     fwd_s3_wdata,
    input  logic              fwd_ex_valid,     // Execute register
    input  bk_pkg::reg_addr_t fwd_ex_rd,
    input  bk_pkg::word_t     fwd_ex_wdata,
    input  logic              fwd_s4_valid,     // Retire register
    input  bk_pkg::reg_addr_t fwd_s4_rd,
    input  bk_pkg::word_t     fwd_s4_wdata,
    bk_stage_if.sender        s3                // To execute
);

    bk_pkg::word_t pc;                          // Decode-aligned PC
    bk_pkg::word_t pc_plus_imm;
    bk_pkg::word_t rs1_val;                     // rs1 after forwarding
    bk_pkg::word_t rs2_val;                     // rs2 after forwarding
    bk_pkg::word_t opr_a;
    bk_pkg::word_t opr_b;
    logic          load;                        // Stage register free
    logic          accept;                      // Micro-op taken this edge

    // Pick the youngest in-flight producer of addr, else the GPR value
    function automatic bk_pkg::word_t fwd_pick(
        input bk_pkg::reg_addr_t addr,
        input bk_pkg::word_t     gpr_val
    );
        bk_pkg::word_t val;
        val = gpr_val;
        if (addr != '0) begin
            if (fwd_s3_valid && (fwd_s3_rd == addr)) begin
                val = fwd_s3_wdata;
            end else if (fwd_ex_valid && (fwd_ex_rd == addr)) begin
                val = fwd_ex_wdata;
            end else if (fwd_s4_valid && (fwd_s4_rd == addr)) begin
                val = fwd_s4_wdata;
            end
        end
        return val;
    endfunction

    // --------------------------------------------------
    // Handshake and PC

    assign load    = !(s3.valid && s3.busy);    // Empty or being drained
    assign in_busy = !load;
    assign accept  = in_valid && load;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= bk_pkg::pc_reset_value;
        end else if (accept) begin
            pc <= pc + bk_pkg::word_t'(bk_pkg::pc_step);
        end
    end

    assign pc_plus_imm = pc + in_imm;           // PC before the step

    // --------------------------------------------------
    // Operand gathering

    assign rs1_addr = in_rs1;
    assign rs2_addr = in_rs2;

    always_comb begin
        rs1_val = fwd_pick(in_rs1, rs1_data);
        rs2_val = fwd_pick(in_rs2, rs2_data);
    end

    // Select bits are one-hot per operand, none set gives zero
    assign opr_a = ({bk_pkg::xlen{in_opr_src[bk_pkg::opra_rs1]}}  & rs1_val)
                 | ({bk_pkg::xlen{in_opr_src[bk_pkg::opra_pcim]}} & pc_plus_imm);
    assign opr_b = ({bk_pkg::xlen{in_opr_src[bk_pkg::oprb_rs2]}}  & rs2_val)
                 | ({bk_pkg::xlen{in_opr_src[bk_pkg::oprb_imm]}}  & in_imm);

    // --------------------------------------------------
    // Pipeline register

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            s3.valid <= 1'b0;
        end else if (load) begin
            s3.valid <= in_valid;               // Empties when nothing offered
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            s3.rd    <= in_rd;
            s3.opr_a <= opr_a;
            s3.opr_b <= opr_b;
            s3.uop   <= in_uop;
        end
    end

endmodule

// ==== source/bk_execute.sv ====
/*
 * Execute stage. ALU on the dispatch register contents and a one-entry
 * result register towards writeback.
 * Exports the unregistered ALU result and the registered result as two
 * forward sources. Shifts use operand B bits 4:0 only.
 */
module bk_execute (
    input  logic              g_clk,            // Clock
    input  logic              g_resetn,         // Sync reset, active low
    bk_stage_if.receiver      s3,               // From dispatch
    bk_stage_if.sender        s4,               // To writeback
    output logic              fwd_s3_valid,     // Result being computed
    output bk_pkg::reg_addr_t fwd_s3_rd,
    output bk_pkg::word_t     fwd_s3_wdata,
    output logic              fwd_ex_valid,     // Result held in register
    output bk_pkg::reg_addr_t fwd_ex_rd,
    output bk_pkg::word_t     fwd_ex_wdata
);

    bk_pkg::word_t alu_result;
    logic [4:0]    shamt;                       // Shift amount

    assign shamt = s3.opr_b[4:0];

    // --------------------------------------------------
    // ALU

    always_comb begin
        case (s3.uop)
            bk_pkg::alu_add:  alu_result = s3.opr_a + s3.opr_b;
            bk_pkg::alu_sub:  alu_result = s3.opr_a - s3.opr_b;
            bk_pkg::alu_and:  alu_result = s3.opr_a & s3.opr_b;
            bk_pkg::alu_or:   alu_result = s3.opr_a | s3.opr_b;
            bk_pkg::alu_xor:  alu_result = s3.opr_a ^ s3.opr_b;
            bk_pkg::alu_sll:  alu_result = s3.opr_a << shamt;
            bk_pkg::alu_srl:  alu_result = s3.opr_a >> shamt;
            bk_pkg::alu_sra:  alu_result = $signed(s3.opr_a) >>> shamt;
            bk_pkg::alu_slt:
                alu_result = bk_pkg::word_t'($signed(s3.opr_a) < $signed(s3.opr_b));
            bk_pkg::alu_sltu: alu_result = bk_pkg::word_t'(s3.opr_a < s3.opr_b);
            default:          alu_result = '0;  // Undefined code
        endcase
    end

    // --------------------------------------------------
    // Result register

    assign s3.busy = s4.valid && s4.busy;       // Full and not draining

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            s4.valid <= 1'b0;
        end else if (!s3.busy) begin
            s4.valid <= s3.valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s3.valid && !s3.busy) begin
            s4.rd    <= s3.rd;
            s4.opr_a <= alu_result;             // Result rides in opr_a
        end
    end

    assign s4.opr_b = '0;                       // Not used past execute
    assign s4.uop   = bk_pkg::alu_add;

    // --------------------------------------------------
    // Forward paths

    assign fwd_s3_valid = s3.valid;
    assign fwd_s3_rd    = s3.rd;
    assign fwd_s3_wdata = alu_result;
    assign fwd_ex_valid = s4.valid;
    assign fwd_ex_rd    = s4.rd;
    assign fwd_ex_wdata = s4.opr_a;

endmodule

// ==== source/bk_gprs.sv ====
/*
 * General purpose registers x1..x31 in flip-flops, cleared by reset.
 * x0 reads zero and drops writes.
 * Reads are combinational and return the old value in the write cycle,
 * so the pipeline must forward a value that is being written.
 */
module bk_gprs (
    input  logic              g_clk,            // Clock
    input  logic              g_resetn,         // Sync reset, active low
    input  bk_pkg::reg_addr_t rs1_addr,         // Read port 1 address
    output bk_pkg::word_t     rs1_data,         // Read port 1 data
    input  bk_pkg::reg_addr_t rs2_addr,         // Read port 2 address
    output bk_pkg::word_t     rs2_data,         // Read port 2 data
    input  logic              rd_wen,           // Write strobe
    input  bk_pkg::reg_addr_t rd_addr,          // Write address
    input  bk_pkg::word_t     rd_data           // Write data
);

    bk_pkg::word_t regs [31:1];                 // No storage for x0

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;           // x0 writes fall through
        end
    end

    // x0 is hard-wired
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== source/bk_pkg.sv ====
/*
 * Shared widths, ALU micro-op codes and operand-source select bits of
 * the integer back end.
 * Micro-op codes outside alu_uop_e produce a result of zero.
 * An operand whose select bits are all clear reads as zero.
 */
package bk_pkg;

    // --------------------------------------------------
    // Widths

    localparam int xlen = 32;                   // Data path width

    typedef logic [xlen-1:0] word_t;            // Register value or operand
    typedef logic [4:0]      reg_addr_t;        // GPR address, x0..x31
    typedef logic [3:0]      opr_src_t;         // Operand source selects

    // --------------------------------------------------
    // Operand source bit positions in opr_src_t

    localparam int opra_rs1  = 0;               // A from rs1
    localparam int opra_pcim = 1;               // A from pc + imm
    localparam int oprb_rs2  = 2;               // B from rs2
    localparam int oprb_imm  = 3;               // B from immediate

    // --------------------------------------------------
    // ALU micro-ops

    typedef enum logic [3:0] {
        alu_add  = 4'd0,                        // a + b
        alu_sub  = 4'd1,                        // a - b
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,                        // Shift by b[4:0]
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,                        // Keeps sign of a
        alu_slt  = 4'd8,                        // Signed compare
        alu_sltu = 4'd9                         // Unsigned compare
    } alu_uop_e;

    // --------------------------------------------------
    // Program counter

    localparam word_t pc_reset_value = 32'h8000_0000; // PC out of reset
    localparam int    pc_step        = 4;       // Every micro-op is 4 bytes

endpackage

// ==== source/bk_stage_if.sv ====
/*
 * One stage-to-stage transfer. A beat moves on a rising edge with valid
 * high and busy low. The sender keeps every field stable while valid and
 * busy are both high.
 * Execute to writeback carries the result in opr_a only.
 */
interface bk_stage_if;

    logic               valid;                  // Sender holds an item
    logic               busy;                   // Receiver cannot take it
    bk_pkg::reg_addr_t  rd;                     // Destination register
    bk_pkg::word_t      opr_a;                  // Operand A or result
    bk_pkg::word_t      opr_b;                  // Operand B
    bk_pkg::alu_uop_e   uop;                    // ALU micro-op

    modport sender (
        output valid,
        output rd,
        output opr_a,
        output opr_b,
        output uop,
        input  busy
    );

    modport receiver (
        input  valid,
        input  rd,
        input  opr_a,
        input  opr_b,
        input  uop,
        output busy
    );

endinterface

// ==== source/bk_top.sv ====
/*
 * Integer back end top level. Takes decoded micro-ops on a valid/busy
 * handshake and retires one result per transfer in issue order.
 * A lone micro-op with no back-pressure is on the retire ports after
 * the third rising edge, counting its accept edge as the first.
 */
module bk_top (
    input  logic              g_clk,            // Clock
    input  logic              g_resetn,         // Sync reset, active low
    input  logic              in_valid,         // Micro-op offered
    output logic              in_busy,          // Micro-op not taken
    input  bk_pkg::reg_addr_t in_rd,
    input  bk_pkg::reg_addr_t in_rs1,
    input  bk_pkg::reg_addr_t in_rs2,
    input  bk_pkg::word_t     in_imm,
    input  bk_pkg::alu_uop_e  in_uop,
    input  bk_pkg::opr_src_t  in_opr_src,
    output logic              ret_valid,        // Result retiring
    input  logic              ret_busy,         // Back-pressure
    output bk_pkg::reg_addr_t ret_rd,
    output bk_pkg::word_t     ret_wdata
);

    bk_stage_if s3_if ();                       // Dispatch to execute
    bk_stage_if s4_if ();                       // Execute to writeback

    bk_pkg::reg_addr_t rs1_addr;
    bk_pkg::reg_addr_t rs2_addr;
    bk_pkg::word_t     rs1_data;
    bk_pkg::word_t     rs2_data;
    logic              fwd_s3_valid;
    bk_pkg::reg_addr_t fwd_s3_rd;
    bk_pkg::word_t     fwd_s3_wdata;
    logic              fwd_ex_valid;
    bk_pkg::reg_addr_t fwd_ex_rd;
    bk_pkg::word_t     fwd_ex_wdata;
    logic              fwd_s4_valid;
    bk_pkg::reg_addr_t fwd_s4_rd;
    bk_pkg::word_t     fwd_s4_wdata;
    logic              gpr_wen;
    bk_pkg::reg_addr_t gpr_rd;
    bk_pkg::word_t     gpr_wdata;

    bk_dispatch u_dispatch (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .in_valid     (in_valid),
        .in_busy      (in_busy),
        .in_rd        (in_rd),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .in_imm       (in_imm),
        .in_uop       (in_uop),
        .in_opr_src   (in_opr_src),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .fwd_s3_valid (fwd_s3_valid),
        .fwd_s3_rd    (fwd_s3_rd),
        .fwd_s3_wdata (fwd_s3_wdata),
        .fwd_ex_valid (fwd_ex_valid),
        .fwd_ex_rd    (fwd_ex_rd),
        .fwd_ex_wdata (fwd_ex_wdata),
        .fwd_s4_valid (fwd_s4_valid),
        .fwd_s4_rd    (fwd_s4_rd),
        .fwd_s4_wdata (fwd_s4_wdata),
        .s3           (s3_if.sender)
    );

    bk_execute u_execute (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .s3           (s3_if.receiver),
        .s4           (s4_if.sender),
        .fwd_s3_valid (fwd_s3_valid),
        .fwd_s3_rd    (fwd_s3_rd),
        .fwd_s3_wdata (fwd_s3_wdata),
        .fwd_ex_valid (fwd_ex_valid),
        .fwd_ex_rd    (fwd_ex_rd),
        .fwd_ex_wdata (fwd_ex_wdata)
    );

    bk_writeback u_writeback (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .s4           (s4_if.receiver),
        .ret_valid    (ret_valid),
        .ret_busy     (ret_busy),
        .ret_rd       (ret_rd),
        .ret_wdata    (ret_wdata),
        .gpr_wen      (gpr_wen),
        .gpr_rd       (gpr_rd),
        .gpr_wdata    (gpr_wdata),
        .fwd_s4_valid (fwd_s4_valid),
        .fwd_s4_rd    (fwd_s4_rd),
        .fwd_s4_wdata (fwd_s4_wdata)
    );

    bk_gprs u_gprs (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .rs1_addr     (rs1_addr),
        .rs1_data     (rs1_data),
        .rs2_addr     (rs2_addr),
        .rs2_data     (rs2_data),
        .rd_wen       (gpr_wen),
        .rd_addr      (gpr_rd),
        .rd_data      (gpr_wdata)
    );

endmodule

// ==== source/bk_writeback.sv ====
/*
 * Writeback stage. Holds the retiring result until ret_busy is low,
 * writes it to the register file on that same edge and reports it on
 * the retire ports. Writes to x0 are dropped by the register file.
 */
module bk_writeback (
    input  logic              g_clk,            // Clock
    input  logic              g_resetn,         // Sync reset, active low
    bk_stage_if.receiver      s4,               // From execute
    output logic              ret_valid,        // Result retiring
    input  logic              ret_busy,         // Outside holds it off
    output bk_pkg::reg_addr_t ret_rd,
    output bk_pkg::word_t     ret_wdata,
    output logic              gpr_wen,          // GPR write strobe
    output bk_pkg::reg_addr_t gpr_rd,
    output bk_pkg::word_t     gpr_wdata,
    output logic              fwd_s4_valid,     // Retire register forward
    output bk_pkg::reg_addr_t fwd_s4_rd,
    output bk_pkg::word_t     fwd_s4_wdata
);

    assign s4.busy = ret_valid && ret_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            ret_valid <= 1'b0;
        end else if (!s4.busy) begin
            ret_valid <= s4.valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s4.valid && !s4.busy) begin
            ret_rd    <= s4.rd;
            ret_wdata <= s4.opr_a;
        end
    end

    // Commit exactly on the retire transfer
    assign gpr_wen   = ret_valid && !ret_busy;
    assign gpr_rd    = ret_rd;
    assign gpr_wdata = ret_wdata;

    assign fwd_s4_valid = ret_valid;            // Covers the write cycle too
    assign fwd_s4_rd    = ret_rd;
    assign fwd_s4_wdata = ret_wdata;

endmodule

// ==== test/bk_checker.sv ====
/*
 * Handshake and reset assertions on the bk_top ports, bound into bk_top.
 * Only the retire side is watched. The input side has no hold rule.
 */
module bk_checker (
    input logic              g_clk,             // Clock
    input logic              g_resetn,          // Sync reset, active low
    input logic              in_busy,
    input logic              ret_valid,
    input logic              ret_busy,
    input bk_pkg::reg_addr_t ret_rd,
    input bk_pkg::word_t     ret_wdata
);
    timeunit 1ns;
    timeprecision 1ps;

    // --------------------------------------------------
    // Retire handshake

    // A held result stays put until taken
    ret_hold_a: assert property (@(posedge g_clk) disable iff (!g_resetn)
        ret_valid && ret_busy |=> ret_valid && $stable(ret_rd) && $stable(ret_wdata))
        else $error("retire result changed while held by ret_busy");

    // Input stalls only when the whole pipe is backed up
    busy_source_a: assert property (@(posedge g_clk) disable iff (!g_resetn)
        in_busy |-> ret_valid && ret_busy)
        else $error("in_busy high without back-pressure on the retire port");

    // --------------------------------------------------
    // Reset

    reset_idle_a: assert property (@(posedge g_clk)
        !g_resetn |=> !ret_valid && !in_busy)
        else $error("pipeline not idle one cycle after reset");

endmodule

// ==== test/bk_tb.sv ====
/*
 * Testbench for bk_top. Opens with three lone micro-ops that check the
 * retire latency, then runs LCG driven micro-ops with random in_valid
 * and ret_busy against an in-order model of the GPRs and the PC.
 * Register addresses stay in x0..x7 so hazards are frequent.
 * Micro-op codes 10..15 are drawn too and must retire as zero.
 */
module bk_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_lone     = 3;              // Directed opening ops
    localparam int n_uops     = 2000;           // Random micro-ops
    localparam int total_uops = n_lone + n_uops;
    localparam int max_cycles = n_uops * 8;     // Timeout limit
    localparam int clk_half   = 50;             // 100 ns period
    localparam int drive_dly  = 10;             // Input skew after edge

    logic              g_clk;
    logic              g_resetn;
    logic              in_valid;
    logic              in_busy;
    bk_pkg::reg_addr_t in_rd;
    bk_pkg::reg_addr_t in_rs1;
    bk_pkg::reg_addr_t in_rs2;
    bk_pkg::word_t     in_imm;
    bk_pkg::alu_uop_e  in_uop;
    bk_pkg::opr_src_t  in_opr_src;
    logic              ret_valid;
    logic              ret_busy;
    bk_pkg::reg_addr_t ret_rd;
    bk_pkg::word_t     ret_wdata;

    logic [31:0]       lcg_state = 32'h83c0;    // Fixed seed
    bk_pkg::word_t     model_regs [32];         // Architectural GPRs
    bk_pkg::word_t     model_pc;                // Architectural PC
    bk_pkg::reg_addr_t exp_rd_q [$];            // Issue order
    bk_pkg::word_t     exp_val_q [$];
    int                cycle_cnt = 0;
    int                issued    = 0;
    int                retired   = 0;
    logic              accepted;                // Offer taken at next edge

    bk_top u_bk_top (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .in_valid   (in_valid),
        .in_busy    (in_busy),
        .in_rd      (in_rd),
        .in_rs1     (in_rs1),
        .in_rs2     (in_rs2),
        .in_imm     (in_imm),
        .in_uop     (in_uop),
        .in_opr_src (in_opr_src),
        .ret_valid  (ret_valid),
        .ret_busy   (ret_busy),
        .ret_rd     (ret_rd),
        .ret_wdata  (ret_wdata)
    );

    bind bk_top bk_checker u_checker (.*);

    // --------------------------------------------------
    // Reporting and compare tasks

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input bk_pkg::word_t got, input bk_pkg::word_t exp,
                              input string what);
        if (got !== exp)
            fail_run($sformatf("Fail %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_rd(input bk_pkg::reg_addr_t got, input bk_pkg::reg_addr_t exp,
                            input string what);
        if (got !== exp)
            fail_run($sformatf("Fail %0t: %s is x%0d, expected x%0d", $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            fail_run($sformatf("Fail %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // --------------------------------------------------
    // Random numbers and model

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Sel 0 or 1 picks the register, 2 the other source, 3 gives zero
    function automatic bk_pkg::opr_src_t make_src(input logic [1:0] a_sel,
                                                  input logic [1:0] b_sel);
        bk_pkg::opr_src_t src;
        src = '0;
        if (a_sel <= 2'd1)
            src[bk_pkg::opra_rs1] = 1'b1;
        else if (a_sel == 2'd2)
            src[bk_pkg::opra_pcim] = 1'b1;
        if (b_sel <= 2'd1)
            src[bk_pkg::oprb_rs2] = 1'b1;
        else if (b_sel == 2'd2)
            src[bk_pkg::oprb_imm] = 1'b1;
        return src;
    endfunction

    function automatic bk_pkg::word_t model_alu(input bk_pkg::alu_uop_e uop,
                                                input bk_pkg::word_t a,
                                                input bk_pkg::word_t b);
        logic [63:0]   ext;                     // Sign extended a
        logic [4:0]    sh;
        bk_pkg::word_t r;
        ext = {{32{a[31]}}, a};
        sh  = b[4:0];
        case (uop)
            bk_pkg::alu_add:  r = a + b;
            bk_pkg::alu_sub:  r = a + ~b + 32'd1;
            bk_pkg::alu_and:  r = a & b;
            bk_pkg::alu_or:   r = a | b;
            bk_pkg::alu_xor:  r = a ^ b;
            bk_pkg::alu_sll:  r = a << sh;
            bk_pkg::alu_srl:  r = a >> sh;
            bk_pkg::alu_sra:  r = bk_pkg::word_t'(ext >> sh);
            bk_pkg::alu_slt:  r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            bk_pkg::alu_sltu: r = {31'b0, a < b};
            default:          r = '0;           // Unused codes
        endcase
        return r;
    endfunction

    // In-order update at acceptance, so later ops see this result
    task automatic model_accept();
        bk_pkg::word_t a;
        bk_pkg::word_t b;
        bk_pkg::word_t res;
        a = '0;
        b = '0;
        if (in_opr_src[bk_pkg::opra_rs1])
            a = model_regs[in_rs1];
        else if (in_opr_src[bk_pkg::opra_pcim])
            a = model_pc + in_imm;              // PC before the step
        if (in_opr_src[bk_pkg::oprb_rs2])
            b = model_regs[in_rs2];
        else if (in_opr_src[bk_pkg::oprb_imm])
            b = in_imm;
        res = model_alu(in_uop, a, b);
        if (in_rd != '0)
            model_regs[in_rd] = res;
        exp_rd_q.push_back(in_rd);
        exp_val_q.push_back(res);
        model_pc = model_pc + bk_pkg::pc_step;
        issued++;
    endtask

    task automatic model_retire();
        if (exp_val_q.size() == 0) begin
            fail_run("A result retired with no micro-op left outstanding");
        end else begin
            check_rd(ret_rd, exp_rd_q.pop_front(), "ret_rd");
            check_word(ret_wdata, exp_val_q.pop_front(), "ret_wdata");
            retired++;
        end
    endtask

    // --------------------------------------------------
    // Cycle helpers

    // Mid-cycle sample of the transfers due at the next edge
    task automatic observe();
        @(negedge g_clk);
        // Stalls only with all three stage registers full and held off
        check_flag(in_busy, (exp_val_q.size() == 3) && ret_busy, "in_busy");
        if (ret_valid && !ret_busy)
            model_retire();
        accepted = in_valid && !in_busy;
        if (accepted)
            model_accept();
    endtask

    task automatic next_edge();
        @(posedge g_clk);
        #drive_dly;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        r = lcg_next();
        ret_busy = (r[31:30] == 2'b00);         // About one cycle in four
        if (!in_valid || accepted) begin        // Held offers stay unchanged
            r          = lcg_next();
            in_rd      = {2'b00, r[31:29]};
            in_rs1     = {2'b00, r[28:26]};
            in_rs2     = {2'b00, r[25:23]};
            in_uop     = bk_pkg::alu_uop_e'(r[22:19]);
            in_opr_src = make_src(r[18:17], r[16:15]);
            r          = lcg_next();
            in_valid   = (issued < total_uops) && (r[31:30] != 2'b00);
            in_imm     = lcg_next();
        end
    endtask

    // Offer one op to an empty pipe and watch ret_valid edge by edge
    task automatic issue_lone(input bk_pkg::reg_addr_t rd, input bk_pkg::reg_addr_t rs1,
                              input bk_pkg::reg_addr_t rs2, input bk_pkg::word_t imm,
                              input bk_pkg::alu_uop_e uop, input bk_pkg::opr_src_t src);
        in_valid   = 1'b1;
        in_rd      = rd;
        in_rs1     = rs1;
        in_rs2     = rs2;
        in_imm     = imm;
        in_uop     = uop;
        in_opr_src = src;
        ret_busy   = 1'b0;
        observe();
        check_flag(accepted, 1'b1, "accept of a lone micro-op");
        for (int i = 1; i <= 3; i++) begin
            next_edge();
            in_valid = 1'b0;
            observe();
            check_flag(ret_valid, i == 3, "ret_valid three cycles after accept");
        end
        next_edge();
    endtask

    // --------------------------------------------------
    // Clock and timeout

    initial begin
        g_clk = 1'b0;
        forever begin
            #clk_half g_clk = ~g_clk;
        end
    end

    always @(posedge g_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles)
            fail_run($sformatf("Timeout after %0d cycles with %0d of %0d results retired",
                               cycle_cnt, retired, total_uops));
    end

    // --------------------------------------------------
    // Test sequence

    initial begin
        g_resetn   = 1'b0;
        in_valid   = 1'b0;
        in_rd      = '0;
        in_rs1     = '0;
        in_rs2     = '0;
        in_imm     = '0;
        in_uop     = bk_pkg::alu_add;
        in_opr_src = '0;
        ret_busy   = 1'b0;
        accepted   = 1'b0;
        model_pc   = bk_pkg::pc_reset_value;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        repeat (10) @(posedge g_clk);
        #drive_dly;
        g_resetn = 1'b1;

        observe();                              // Idle state out of reset
        check_flag(ret_valid, 1'b0, "ret_valid after reset");
        check_flag(in_busy, 1'b0, "in_busy after reset");
        next_edge();

        // x1 = x2 + 5 with x2 still zero
        issue_lone(5'd1, 5'd2, 5'd0, 32'd5, bk_pkg::alu_add, make_src(2'd0, 2'd2));
        // x2 = pc + 16
        issue_lone(5'd2, 5'd0, 5'd0, 32'h10, bk_pkg::alu_add, make_src(2'd2, 2'd3));
        // x3 = x2 - x1 through the register file
        issue_lone(5'd3, 5'd2, 5'd1, 32'd0, bk_pkg::alu_sub, make_src(2'd0, 2'd0));

        while (issued < total_uops) begin
            drive_random();
            observe();
            next_edge();
        end

        while (exp_val_q.size() > 0) begin      // Drain under back-pressure
            drive_random();
            observe();
            next_edge();
        end

        ret_busy = 1'b0;
        repeat (4) begin                        // A stray retire fails here
            observe();
            next_edge();
        end

        if (retired == total_uops) begin
            $display("** PASS **");
            $finish;
        end else begin
            fail_run($sformatf("Only %0d of %0d micro-ops retired", retired, total_uops));
        end
    end

endmodule
